//--- src/alu_macros.svh
/*
 * ALU pipeline widths and RISC-V major opcode values
 * Shared by the package and the RTL that decodes or builds operands
 */
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// Data path and field widths
`define ALU_XLEN     32
`define ALU_INST_W   32
`define ALU_TAG_W    6
`define ALU_RNID_W   7
`define ALU_SHAMT_W  5

// ----------------------------------------------------------------------
// Major opcodes, instruction bits 6:0
// ----------------------------------------------------------------------
`define ALU_OPC_LUI    7'b0110111
`define ALU_OPC_AUIPC  7'b0010111
`define ALU_OPC_OP     7'b0110011
`define ALU_OPC_OPIMM  7'b0010011

`endif

//--- src/alu_pkg.sv
/*
 * ALU pipeline package
 * Width types, decode enums and the issue and result records
 * that travel between the pipeline stages
 */
`include "alu_macros.svh"

package alu_pkg;

  typedef logic [`ALU_XLEN-1:0]   xlen_t;
  typedef logic [`ALU_INST_W-1:0] inst_t;
  typedef logic [`ALU_TAG_W-1:0]  tag_t;
  typedef logic [`ALU_RNID_W-1:0] rnid_t;

  // ----------------------------------------------------------------------
  // Decoded control
  // ----------------------------------------------------------------------
  typedef enum logic [3:0] {
    OP_NONE,
    OP_LUI,
    OP_AUIPC,
    OP_ADD,
    OP_SUB,
    OP_XOR,
    OP_OR,
    OP_AND,
    OP_SLL,
    OP_SRL,
    OP_SRA,
    OP_SLT,
    OP_SLTU
  } alu_op_t;

  typedef enum logic [1:0] {
    IMM_NONE,   // Operand 2 from rs2
    IMM_I,      // Sign-extended bits 31:20
    IMM_SHAMT   // Shift amount
  } imm_sel_t;

  typedef struct packed {
    alu_op_t  op;
    imm_sel_t imm;
  } alu_ctrl_t;

  // ----------------------------------------------------------------------
  // Pipeline records
  // ----------------------------------------------------------------------
  typedef struct packed {
    logic  valid;
    inst_t inst;
    xlen_t pc;
    xlen_t rs1_data;
    xlen_t rs2_data;   // Holds the immediate after ex0 when one is selected
    tag_t  tag;
    rnid_t rd;
    logic  wr_en;
  } issue_t;

  typedef struct packed {
    logic  done_valid;
    tag_t  tag;
    logic  wr_valid;
    rnid_t rd;
    xlen_t data;
  } result_t;

endpackage

//--- src/alu_decoder.sv
/*
 * ALU instruction decoder
 * Maps LUI, AUIPC and the OP / OP-IMM integer group to an ALU
 * operation and an immediate kind. Purely combinational
 */
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_decoder import alu_pkg::*; (
  input  inst_t     i_inst,
  output alu_ctrl_t o_ctrl
);

  logic [6:0] w_opcode;
  logic [2:0] w_funct3;
  logic [6:0] w_funct7;
  logic       w_f7_zero;
  logic       w_f7_alt;     // Only bit 5 set

  assign w_opcode  = i_inst[6:0];
  assign w_funct3  = i_inst[14:12];
  assign w_funct7  = i_inst[31:25];
  assign w_f7_zero = (w_funct7 == 7'b0000000);
  assign w_f7_alt  = (w_funct7 == 7'b0100000);

  always_comb begin
    o_ctrl.op  = OP_NONE;
    o_ctrl.imm = IMM_NONE;

    case (w_opcode)
      `ALU_OPC_LUI:   o_ctrl.op = OP_LUI;
      `ALU_OPC_AUIPC: o_ctrl.op = OP_AUIPC;

      // ------------------------------------------------------------------
      // Register forms
      // ------------------------------------------------------------------
      `ALU_OPC_OP: begin
        case (w_funct3)
          3'b000: begin
            if (w_f7_zero)     o_ctrl.op = OP_ADD;
            else if (w_f7_alt) o_ctrl.op = OP_SUB;
          end
          3'b001: if (w_f7_zero) o_ctrl.op = OP_SLL;
          3'b010: if (w_f7_zero) o_ctrl.op = OP_SLT;
          3'b011: if (w_f7_zero) o_ctrl.op = OP_SLTU;
          3'b100: if (w_f7_zero) o_ctrl.op = OP_XOR;
          3'b101: begin
            if (w_f7_zero)     o_ctrl.op = OP_SRL;
            else if (w_f7_alt) o_ctrl.op = OP_SRA;
          end
          3'b110: if (w_f7_zero) o_ctrl.op = OP_OR;
          3'b111: if (w_f7_zero) o_ctrl.op = OP_AND;
          default: o_ctrl.op = OP_NONE;
        endcase
      end

      // ------------------------------------------------------------------
      // Immediate forms. Upper bits are the immediate except for shifts
      // ------------------------------------------------------------------
      `ALU_OPC_OPIMM: begin
        o_ctrl.imm = IMM_I;
        case (w_funct3)
          3'b000: o_ctrl.op = OP_ADD;
          3'b010: o_ctrl.op = OP_SLT;
          3'b011: o_ctrl.op = OP_SLTU;
          3'b100: o_ctrl.op = OP_XOR;
          3'b110: o_ctrl.op = OP_OR;
          3'b111: o_ctrl.op = OP_AND;
          3'b001: begin
            if (w_f7_zero) begin
              o_ctrl.op  = OP_SLL;
              o_ctrl.imm = IMM_SHAMT;
            end else begin
              o_ctrl.imm = IMM_NONE;   // Reserved shift encoding
            end
          end
          3'b101: begin
            if (w_f7_zero || w_f7_alt) begin
              o_ctrl.op  = w_f7_alt ? OP_SRA : OP_SRL;
              o_ctrl.imm = IMM_SHAMT;
            end else begin
              o_ctrl.imm = IMM_NONE;
            end
          end
          default: o_ctrl.imm = IMM_NONE;
        endcase
      end

      default: begin
        o_ctrl.op  = OP_NONE;   // Unknown opcode still completes
        o_ctrl.imm = IMM_NONE;
      end
    endcase
  end

endmodule

//--- src/alu_operand_stage.sv
/*
 * ALU ex0 stage
 * Selects the second operand, drops flushed items and registers
 * the issue record and its decoded control into ex1
 */
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_operand_stage import alu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_flush,
  input  issue_t    i_issue,
  input  alu_ctrl_t i_ctrl,
  output issue_t    o_ex1_issue,
  output alu_ctrl_t o_ex1_ctrl
);

  xlen_t  w_imm_i;
  xlen_t  w_imm_shamt;
  xlen_t  w_op2;
  issue_t w_ex1_next;

  issue_t    r_ex1_issue;
  alu_ctrl_t r_ex1_ctrl;

  // ----------------------------------------------------------------------
  // Operand 2
  // ----------------------------------------------------------------------
  assign w_imm_i     = {{(`ALU_XLEN-12){i_issue.inst[31]}}, i_issue.inst[31:20]};
  assign w_imm_shamt = {{(`ALU_XLEN-`ALU_SHAMT_W){1'b0}}, i_issue.inst[20 +: `ALU_SHAMT_W]};

  always_comb begin
    case (i_ctrl.imm)
      IMM_I:     w_op2 = w_imm_i;
      IMM_SHAMT: w_op2 = w_imm_shamt;
      default:   w_op2 = i_issue.rs2_data;
    endcase
  end

  always_comb begin
    w_ex1_next          = i_issue;
    w_ex1_next.rs2_data = w_op2;
    w_ex1_next.valid    = i_issue.valid & ~i_flush;   // Flushed in ex0
  end

  // ----------------------------------------------------------------------
  // Ex1 registers
  // ----------------------------------------------------------------------
  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex1_issue <= '0;
      r_ex1_ctrl  <= '0;
    end else begin
      r_ex1_issue <= w_ex1_next;
      r_ex1_ctrl  <= i_ctrl;
    end
  end

  assign o_ex1_issue = r_ex1_issue;
  assign o_ex1_ctrl  = r_ex1_ctrl;

  // Decoder never hands a live item an undefined immediate kind
  a_ex1_imm_legal: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_ex1_issue.valid |-> (r_ex1_ctrl.imm inside {IMM_NONE, IMM_I, IMM_SHAMT})
  ) else $error("ex1 item carries illegal imm select %0d", r_ex1_ctrl.imm);

endmodule

//--- src/alu_execute_stage.sv
/*
 * ALU ex1 stage
 * Computes the integer result and registers it into ex2 together
 * with the completion and register-write report
 */
`timescale 1ns/1ns
`include "alu_macros.svh"

module alu_execute_stage import alu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_flush,
  input  issue_t    i_ex1_issue,
  input  alu_ctrl_t i_ex1_ctrl,
  output result_t   o_result
);

  xlen_t                  w_op1;
  xlen_t                  w_op2;
  logic [`ALU_SHAMT_W-1:0] w_shamt;
  xlen_t                  w_upper_imm;
  xlen_t                  w_alu_out;
  logic                   w_survive;
  result_t                w_ex2_next;

  result_t r_ex2_result;

  assign w_op1       = i_ex1_issue.rs1_data;
  assign w_op2       = i_ex1_issue.rs2_data;   // Already immediate where selected
  assign w_shamt     = w_op2[`ALU_SHAMT_W-1:0];
  assign w_upper_imm = {i_ex1_issue.inst[31:12], 12'h000};

  // ----------------------------------------------------------------------
  // Integer ALU
  // ----------------------------------------------------------------------
  always_comb begin
    case (i_ex1_ctrl.op)
      OP_LUI:   w_alu_out = w_upper_imm;
      OP_AUIPC: w_alu_out = i_ex1_issue.pc + w_upper_imm;
      OP_ADD:   w_alu_out = w_op1 + w_op2;
      OP_SUB:   w_alu_out = w_op1 - w_op2;
      OP_XOR:   w_alu_out = w_op1 ^ w_op2;
      OP_OR:    w_alu_out = w_op1 | w_op2;
      OP_AND:   w_alu_out = w_op1 & w_op2;
      OP_SLL:   w_alu_out = w_op1 << w_shamt;
      OP_SRL:   w_alu_out = w_op1 >> w_shamt;
      OP_SRA:   w_alu_out = $signed(w_op1) >>> w_shamt;
      OP_SLT: begin
        w_alu_out = {{(`ALU_XLEN-1){1'b0}}, ($signed(w_op1) < $signed(w_op2))};
      end
      OP_SLTU: begin
        w_alu_out = {{(`ALU_XLEN-1){1'b0}}, (w_op1 < w_op2)};
      end
      default:  w_alu_out = '0;   // OP_NONE
    endcase
  end

  // ----------------------------------------------------------------------
  // Report fields
  // ----------------------------------------------------------------------
  assign w_survive = i_ex1_issue.valid & ~i_flush;

  always_comb begin
    w_ex2_next.done_valid = w_survive;
    w_ex2_next.tag        = i_ex1_issue.tag;
    w_ex2_next.wr_valid   = w_survive & i_ex1_issue.wr_en;
    w_ex2_next.rd         = i_ex1_issue.rd;
    w_ex2_next.data       = w_alu_out;
  end

  always_ff @(posedge i_clk, negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_ex2_result <= '0;
    end else begin
      r_ex2_result <= w_ex2_next;
    end
  end

  assign o_result = r_ex2_result;

  a_wr_needs_done: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_result.wr_valid |-> o_result.done_valid
  ) else $error("register write reported without completion");

  // Operands arrive with the issue, so X here means a dirty source upstream
  a_data_known: assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    o_result.done_valid |-> !$isunknown(o_result.data)
  ) else $error("reported data is unknown");

endmodule

//--- src/alu_pipe.sv
/*
 * Integer ALU pipeline top
 * ex0 decode and operand select, ex1 execute, ex2 report.
 * One issue per cycle, result two cycles later
 */
`timescale 1ns/1ns

module alu_pipe import alu_pkg::*; (
  input  logic    i_clk,
  input  logic    i_reset_n,
  input  logic    i_flush,    // Commit flush
  input  issue_t  i_issue,
  output result_t o_result
);

  alu_ctrl_t w_ex0_ctrl;
  issue_t    w_ex1_issue;
  alu_ctrl_t w_ex1_ctrl;

  // ----------------------------------------------------------------------
  // Ex0
  // ----------------------------------------------------------------------
  alu_decoder u_decoder (
    .i_inst (i_issue.inst),
    .o_ctrl (w_ex0_ctrl)
  );

  alu_operand_stage u_operand_stage (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_issue     (i_issue),
    .i_ctrl      (w_ex0_ctrl),
    .o_ex1_issue (w_ex1_issue),
    .o_ex1_ctrl  (w_ex1_ctrl)
  );

  // Ex1 compute, ex2 holds the report
  alu_execute_stage u_execute_stage (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_flush     (i_flush),
    .i_ex1_issue (w_ex1_issue),
    .i_ex1_ctrl  (w_ex1_ctrl),
    .o_result    (o_result)
  );

endmodule

//--- tb/alu_check_tasks.svh
/*
 * Compare tasks for the ALU pipeline testbench
 * One task per result field type, plus the report check built on them
 */
`ifndef ALU_CHECK_TASKS_SVH
`define ALU_CHECK_TASKS_SVH

task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    data_errs++;
  end
endtask

task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %b, got %b", $time, name, exp, act);
    report_errs++;
  end
endtask

task automatic check_tag(input string name, input tag_t exp, input tag_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    report_errs++;
  end
endtask

task automatic check_rnid(input string name, input rnid_t exp, input rnid_t act);
  if (act !== exp) begin
    $display("ERROR at %0t ns: %s expected %h, got %h", $time, name, exp, act);
    report_errs++;
  end
endtask

// Tag and rd only mean something on a completed item
task automatic check_report(input logic exp_done, input logic act_done,
                            input tag_t exp_tag, input tag_t act_tag,
                            input logic exp_wr, input logic act_wr,
                            input rnid_t exp_rd, input rnid_t act_rd);
  check_flag("o_result.done_valid", exp_done, act_done);
  check_flag("o_result.wr_valid", exp_wr, act_wr);
  if (exp_done) begin
    check_tag("o_result.tag", exp_tag, act_tag);
    check_rnid("o_result.rd", exp_rd, act_rd);
  end
endtask

`endif

//--- tb/tb_alu_pipe.sv
/*
 * Testbench for the integer ALU pipeline
 * Reads issue patterns from a file, schedules issues with random gaps
 * and commit flushes, and checks every report against a scoreboard
 */
`timescale 1ns/1ns
`include "alu_macros.svh"

module tb_alu_pipe import alu_pkg::*; ();

  localparam int CLK_PERIOD  = 8;
  localparam int MAX_PAT     = 64;
  localparam int MAX_CYC     = MAX_PAT * 4 + 16;
  localparam int FIRST_ISSUE = 3;   // Idle cycles after reset

  typedef struct packed {
    int      due;
    result_t exp;
  } sb_entry_t;

  logic    i_clk;
  logic    i_reset_n;
  logic    i_flush;
  issue_t  i_issue;
  result_t o_result;

  // Pattern table
  inst_t pat_inst [MAX_PAT];
  xlen_t pat_pc   [MAX_PAT];
  xlen_t pat_rs1  [MAX_PAT];
  xlen_t pat_rs2  [MAX_PAT];
  xlen_t pat_exp  [MAX_PAT];
  tag_t  pat_tag  [MAX_PAT];
  rnid_t pat_rd   [MAX_PAT];
  logic  pat_wr_en[MAX_PAT];
  logic  pat_b2b  [MAX_PAT];
  int    pat_flush[MAX_PAT];   // 0 none, 1 at issue, 2 one cycle later
  int    pat_issue[MAX_PAT];

  logic        flush_at[MAX_CYC];
  sb_entry_t   sb_q[$];
  logic [31:0] lfsr_state;
  logic        sched_ready = 1'b0;
  int          n_pat       = 0;
  int          next_pat    = 0;
  int          last_cyc    = 0;
  int          data_errs   = 0;
  int          report_errs = 0;
  int          proto_errs  = 0;

  `include "alu_check_tasks.svh"

  alu_pipe dut (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_flush   (i_flush),
    .i_issue   (i_issue),
    .o_result  (o_result)
  );

  initial begin
    i_clk = 1'b0;
    forever #(CLK_PERIOD / 2) i_clk = ~i_clk;
  end

  // ----------------------------------------------------------------------
  // Random gaps, x^32 + x^22 + x^2 + x + 1
  // ----------------------------------------------------------------------
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic int random_bits(input int n);
    int v;
    v = 0;
    for (int b = 0; b < n; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = (v << 1) | int'(lfsr_state[0]);
    end
    return v;
  endfunction

  task automatic load_patterns();
    int          fd;
    int          cnt;
    string       line;
    logic [31:0] f_inst, f_pc, f_rs1, f_rs2, f_tag, f_rd, f_wr, f_flush, f_b2b, f_exp;
    fd = $fopen("tb/alu_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file tb/alu_patterns.txt");
      proto_errs++;
    end else begin
      while (!$feof(fd) && n_pat < MAX_PAT) begin
        line = "";
        void'($fgets(line, fd));
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", f_inst, f_pc, f_rs1,
                      f_rs2, f_tag, f_rd, f_wr, f_flush, f_b2b, f_exp);
        if (cnt == 10) begin   // Comment and blank lines fall through
          pat_inst[n_pat]  = f_inst;
          pat_pc[n_pat]    = f_pc;
          pat_rs1[n_pat]   = f_rs1;
          pat_rs2[n_pat]   = f_rs2;
          pat_tag[n_pat]   = f_tag[`ALU_TAG_W-1:0];
          pat_rd[n_pat]    = f_rd[`ALU_RNID_W-1:0];
          pat_wr_en[n_pat] = f_wr[0];
          pat_flush[n_pat] = int'(f_flush);
          pat_b2b[n_pat]   = f_b2b[0];
          pat_exp[n_pat]   = f_exp;
          n_pat++;
        end
      end
      $fclose(fd);
    end
    if (n_pat == 0) begin
      $display("No patterns were read, nothing was tested");
      proto_errs++;
    end
  endtask

  // Issue cycle of every item and the cycles where the flush is high
  task automatic build_schedule();
    int cyc;
    cyc = FIRST_ISSUE;
    for (int c = 0; c < MAX_CYC; c++) flush_at[c] = 1'b0;
    for (int i = 0; i < n_pat; i++) begin
      if (i > 0) begin
        cyc = pat_issue[i-1] + 1;
        if (!pat_b2b[i]) cyc = cyc + random_bits(2);   // Gap of 0 to 3
      end
      pat_issue[i] = cyc;
      if (pat_flush[i] == 1) flush_at[cyc] = 1'b1;
      else if (pat_flush[i] == 2) flush_at[cyc + 1] = 1'b1;
      last_cyc = cyc;
    end
  endtask

  // ----------------------------------------------------------------------
  // Per-cycle stimulus and checking, both on the falling edge
  // ----------------------------------------------------------------------
  task automatic drive_cycle(input int c);
    sb_entry_t ent;
    logic      killed;
    i_issue = '0;
    i_flush = flush_at[c];
    if (next_pat < n_pat && pat_issue[next_pat] == c) begin
      i_issue.valid    = 1'b1;
      i_issue.inst     = pat_inst[next_pat];
      i_issue.pc       = pat_pc[next_pat];
      i_issue.rs1_data = pat_rs1[next_pat];
      i_issue.rs2_data = pat_rs2[next_pat];
      i_issue.tag      = pat_tag[next_pat];
      i_issue.rd       = pat_rd[next_pat];
      i_issue.wr_en    = pat_wr_en[next_pat];
      killed = flush_at[c] | flush_at[c + 1];   // Flushed in ex0 or ex1
      ent.due            = c + 2;
      ent.exp.done_valid = ~killed;
      ent.exp.wr_valid   = ~killed & pat_wr_en[next_pat];
      ent.exp.tag        = pat_tag[next_pat];
      ent.exp.rd         = pat_rd[next_pat];
      ent.exp.data       = pat_exp[next_pat];
      sb_q.push_back(ent);
      next_pat++;
    end
  endtask

  task automatic check_cycle(input int c);
    sb_entry_t ent;
    if (sb_q.size() > 0 && sb_q[0].due == c) begin
      ent = sb_q.pop_front();
      if (ent.exp.done_valid && !o_result.done_valid) begin
        $display("Result for tag %0h was due at %0t ns but did not appear",
                 ent.exp.tag, $time);
        proto_errs++;
      end else begin
        check_report(ent.exp.done_valid, o_result.done_valid, ent.exp.tag, o_result.tag,
                     ent.exp.wr_valid, o_result.wr_valid, ent.exp.rd, o_result.rd);
        if (ent.exp.done_valid) check_data("o_result.data", ent.exp.data, o_result.data);
      end
    end else if (o_result.done_valid || o_result.wr_valid) begin
      $display("A result with tag %0h appeared at %0t ns while no item was due",
               o_result.tag, $time);
      proto_errs++;
    end
  endtask

  initial begin
    i_reset_n  = 1'b0;
    i_flush    = 1'b0;
    i_issue    = '0;
    lfsr_state = 32'hdd909276;
    load_patterns();
    build_schedule();
    sched_ready = 1'b1;
    repeat (4) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    for (int cyc = 0; cyc <= last_cyc + 3; cyc++) begin
      @(negedge i_clk);
      check_cycle(cyc);
      drive_cycle(cyc);
    end
    if (sb_q.size() != 0) begin
      $display("%0d expected results were never reported", sb_q.size());
      proto_errs++;
    end
    $display("Error counts: data %0d, report %0d, protocol %0d",
             data_errs, report_errs, proto_errs);
    if (data_errs + report_errs + proto_errs == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

  // Watchdog, sized from the pattern count
  initial begin
    wait (sched_ready);
    #((n_pat * 5 + 50) * CLK_PERIOD);
    $display("Timeout after %0d clock periods, the run did not finish", n_pat * 5 + 50);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- tb/alu_patterns.txt
# inst pc rs1 rs2 tag rd wr_en flush b2b expected_data (all hex)
# flush: 0 none, 1 at issue, 2 one cycle after issue; b2b 1 issues right after the previous item
# Register forms, issued back to back
007302B3 00001000 00000005 00000007 01 05 1 0 0 0000000C
007302B3 00001004 7FFFFFFF 00000001 02 06 1 0 1 80000000
407302B3 00001008 00000005 00000007 03 07 1 0 1 FFFFFFFE
407302B3 0000100C 80000000 00000001 04 08 1 0 1 7FFFFFFF
007342B3 00001010 F0F0F0F0 0FF00FF0 05 09 1 0 1 FF00FF00
007362B3 00001014 12340000 00005678 06 0A 1 0 1 12345678
007372B3 00001018 FFFF0000 12345678 07 0B 1 0 1 12340000
007312B3 0000101C 00000001 00000024 08 0C 1 0 1 00000010
007312B3 00001020 80000001 0000001F 09 0D 1 0 0 80000000
007352B3 00001024 80000000 00000004 0A 0E 1 0 0 08000000
407352B3 00001028 80000000 00000004 0B 0F 1 0 0 F8000000
407352B3 0000102C 7FFFFFF0 00000021 0C 10 1 0 0 3FFFFFF8
007322B3 00001030 FFFFFFFF 00000001 0D 11 1 0 0 00000001
007322B3 00001034 00000001 FFFFFFFF 0E 12 1 0 0 00000000
007332B3 00001038 FFFFFFFF 00000001 0F 13 1 0 0 00000000
007332B3 0000103C 00000001 FFFFFFFF 10 14 1 0 0 00000001
007322B3 00001040 80000000 7FFFFFFF 11 15 1 0 0 00000001
# Immediate forms, rs2 data must be ignored
12330293 00001044 00001000 DEADBEEF 12 16 1 0 0 00001123
FFF30293 00001048 00000000 DEADBEEF 13 17 1 0 0 FFFFFFFF
80030293 0000104C 00001000 DEADBEEF 14 18 1 0 0 00000800
FFF34293 00001050 A5A5A5A5 DEADBEEF 15 19 1 0 0 5A5A5A5A
FFB32293 00001054 FFFFFFFA DEADBEEF 16 1A 1 0 0 00000001
FFF33293 00001058 FFFFFFFE 00000000 17 1B 1 0 0 00000001
00431293 0000105C 0000000F DEADBEEF 18 1C 1 0 0 000000F0
40835293 00001060 80000000 DEADBEEF 19 1D 1 0 0 FF800000
01F35293 00001064 80000000 DEADBEEF 1A 1E 1 0 0 00000001
0F036293 00001068 0000000F DEADBEEF 1B 1F 1 0 0 000000FF
7FF37293 0000106C FFFFFFFF DEADBEEF 1C 20 1 0 0 000007FF
# Upper immediates
123452B7 00001070 DEADBEEF DEADBEEF 1D 21 1 0 0 12345000
FFFFF2B7 00001074 00000000 00000000 1E 22 1 0 0 FFFFF000
00001297 80000000 00000000 00000000 1F 23 1 0 0 80001000
FFFFF297 00000100 00000000 00000000 20 24 1 0 0 FFFFF100
# Unknown encodings and a completion without register write
00032283 00001080 12345678 00000001 21 25 1 0 0 00000000
027302B3 00001084 00000006 00000007 22 26 1 0 0 00000000
007302B3 00001088 00000003 00000004 23 27 0 0 0 00000007
# Flush at issue kills this item and the one in ex1
007302B3 0000108C 00000010 00000001 24 28 1 0 0 00000011
407302B3 00001090 00000010 00000001 25 29 1 0 1 0000000F
007342B3 00001094 0000FFFF 000000FF 26 2A 1 1 1 0000FF00
# Flush one cycle later kills this item and the next one in ex0
007362B3 00001098 00000F00 000000F0 27 2B 1 0 0 00000FF0
007372B3 0000109C 0000FFFF 00000F0F 28 2C 1 2 1 00000F0F
007302B3 000010A0 00000001 00000002 29 2D 1 0 1 00000003
007302B3 000010A4 00000100 00000200 2A 2E 1 0 0 00000300
407302B3 000010A8 00000300 00000100 2B 2F 1 0 1 00000200

//--- alu_pipe.f
+incdir+src
+incdir+tb
src/alu_pkg.sv
src/alu_decoder.sv
src/alu_operand_stage.sv
src/alu_execute_stage.sv
src/alu_pipe.sv
tb/tb_alu_pipe.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the ALU pipeline testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
  --top-module tb_alu_pipe -f alu_pipe.f -o tb_alu_pipe

sim_out=$(./obj_dir/tb_alu_pipe)
echo "$sim_out"

if grep -qx "Testbench passed" <<< "$sim_out"; then
  exit 0
fi
exit 1
